// File: rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// fetch starts here after reset
`define RV_RESET_PC   32'h0000_0000

// addi x0, x0, 0
`define RV_NOP        32'h0000_0013

// major opcodes of the supported subset
`define RV_OP_REG     7'b0110011
`define RV_OP_IMM     7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111

`endif

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word seen through every format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_slt, alu_pass_b, alu_mul
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_u       inst;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rs1, rs2, rd;
        logic [31:0] rs1_data, rs2_data, imm;
        alu_op_e     alu_op;
        logic        alu_src_imm, branch, bne, jal, mem_ren, mem_wen, reg_wen;
    } id_ex_t;

    // result is the alu value, the product or the link address
    typedef struct packed {
        logic        valid;
        logic [31:0] result, store_data;
        logic [4:0]  rd;
        logic        mem_ren, mem_wen, reg_wen;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] result, load_data;
        logic [4:0]  rd;
        logic        mem_to_reg, reg_wen;
    } mem_wb_t;

    typedef struct packed {
        logic        wen;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_fetch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              icache_stall,
    input  rv_pkg::redirect_t redirect,
    output logic              icache_ren,
    output logic [29:0]       icache_addr,
    input  logic [31:0]       icache_rdata,
    output rv_pkg::if_id_t    if_id
);

    localparam rv_pkg::inst_u nop_inst = `RV_NOP;

    logic [31:0] pc;

    // the cache is read every cycle and a miss just holds the pc
    assign icache_ren  = 1'b1;
    assign icache_addr = pc[31:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `RV_RESET_PC;
            if_id.valid <= 1'b0;
            if_id.inst  <= nop_inst;
        end else if (redirect.taken) begin
            // drop the word fetched down the wrong path
            pc          <= redirect.target;
            if_id.valid <= 1'b0;
            if_id.inst  <= nop_inst;
        end else if (!stall) begin
            if (icache_stall) begin
                if_id.valid <= 1'b0;
                if_id.inst  <= nop_inst;
            end else begin
                pc          <= pc + 32'd4;
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.inst  <= icache_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  rv_pkg::wb_t wb,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_n && wb.wen && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // writeback of the same cycle bypasses the array
    assign rs1_data = (rs1 == 5'd0) ? 32'd0 :
                      (wb.wen && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 :
                      (wb.wen && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_decode (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           flush,
    input  rv_pkg::if_id_t if_id,
    input  logic [31:0]    rs1_data,
    input  logic [31:0]    rs2_data,
    output logic [4:0]     rs1,
    output logic [4:0]     rs2,
    output logic           load_use,
    output rv_pkg::id_ex_t id_ex
);

    rv_pkg::inst_u  inst;
    rv_pkg::id_ex_t dec;
    logic           use_rs1;
    logic           use_rs2;

    assign inst = if_id.inst;
    assign rs1  = inst.r_fmt.rs1;
    assign rs2  = inst.r_fmt.rs2;

    always_comb begin
        dec          = '0;
        dec.valid    = if_id.valid;
        dec.pc       = if_id.pc;
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.rd       = inst.r_fmt.rd;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        case (inst.r_fmt.opcode)
            `RV_OP_REG: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.reg_wen = 1'b1;
                case (inst.r_fmt.funct3)
                    3'b010:  dec.alu_op = rv_pkg::alu_slt;
                    3'b100:  dec.alu_op = rv_pkg::alu_xor;
                    3'b110:  dec.alu_op = rv_pkg::alu_or;
                    3'b111:  dec.alu_op = rv_pkg::alu_and;
                    default: dec.alu_op = inst.r_fmt.funct7[5] ? rv_pkg::alu_sub
                                                                : rv_pkg::alu_add;
                endcase
                // M extension shares the opcode with funct7 bit 0
                if (inst.r_fmt.funct7[0]) begin
                    dec.alu_op = rv_pkg::alu_mul;
                end
            end
            `RV_OP_IMM, `RV_OP_LOAD: begin
                use_rs1         = 1'b1;
                dec.imm         = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                dec.alu_src_imm = 1'b1;
                dec.reg_wen     = 1'b1;
                dec.mem_ren     = (inst.r_fmt.opcode == `RV_OP_LOAD);
            end
            `RV_OP_LUI: begin
                dec.imm         = {inst.u_fmt.imm, 12'd0};
                dec.alu_op      = rv_pkg::alu_pass_b;
                dec.alu_src_imm = 1'b1;
                dec.reg_wen     = 1'b1;
            end
            `RV_OP_STORE: begin
                use_rs1         = 1'b1;
                use_rs2         = 1'b1;
                dec.imm         = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi,
                                   inst.s_fmt.imm_lo};
                dec.alu_src_imm = 1'b1;
                dec.mem_wen     = 1'b1;
            end
            `RV_OP_BRANCH: begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec.imm    = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                              inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
                dec.branch = 1'b1;
                dec.bne    = inst.b_fmt.funct3[0];
            end
            `RV_OP_JAL: begin
                dec.imm     = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20,
                               inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                               inst.j_fmt.imm_10_1, 1'b0};
                dec.jal     = 1'b1;
                dec.reg_wen = 1'b1;
            end
            default: begin
                // anything else retires as a nop
            end
        endcase
        // writes to x0 are dropped here so forwarding never sees them
        dec.reg_wen = dec.reg_wen && (dec.rd != 5'd0);
    end

    // load in execute feeding the instruction in decode
    assign load_use = if_id.valid && id_ex.valid && id_ex.mem_ren && (id_ex.rd != 5'd0) &&
                      ((use_rs1 && rs1 == id_ex.rd) || (use_rs2 && rs2 == id_ex.rd));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex       <= dec;
            id_ex.valid <= dec.valid && !flush && !load_use;
        end
    end

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::wb_t       wb,
    output rv_pkg::ex_mem_t   ex_mem,
    output rv_pkg::redirect_t redirect
);

    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic        held;
    logic [31:0] held_a;
    logic [31:0] held_b;

    // a load in mem carries its address so it is never a forward source
    function automatic logic [31:0] forward(input logic [4:0] rs, input logic [31:0] rf_data);
        if (ex_mem.valid && ex_mem.reg_wen && !ex_mem.mem_ren && ex_mem.rd == rs) begin
            return ex_mem.result;
        end else if (wb.wen && wb.rd == rs) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    always_comb begin
        fwd_a = forward(id_ex.rs1, id_ex.rs1_data);
        fwd_b = forward(id_ex.rs2, id_ex.rs2_data);
    end

    // writeback only lasts one cycle of a memory hold
    // so operands are captured in that first cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else begin
            held <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall && !held) begin
            held_a <= fwd_a;
            held_b <= fwd_b;
        end
    end

    assign op_a  = held ? held_a : fwd_a;
    assign op_b  = held ? held_b : fwd_b;
    assign alu_b = id_ex.alu_src_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::alu_sub:    alu_out = op_a - alu_b;
            rv_pkg::alu_and:    alu_out = op_a & alu_b;
            rv_pkg::alu_or:     alu_out = op_a | alu_b;
            rv_pkg::alu_xor:    alu_out = op_a ^ alu_b;
            rv_pkg::alu_slt:    alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            rv_pkg::alu_pass_b: alu_out = alu_b;
            rv_pkg::alu_mul:    alu_out = op_a * alu_b;
            default:            alu_out = op_a + alu_b;
        endcase
    end

    // bne inverts the equality test
    assign redirect.taken  = id_ex.valid && !stall &&
                             (id_ex.jal || (id_ex.branch && ((op_a == op_b) != id_ex.bne)));
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else if (!stall) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= id_ex.jal ? id_ex.pc + 32'd4 : alu_out;
            ex_mem.store_data <= op_b;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_ren    <= id_ex.mem_ren;
            ex_mem.mem_wen    <= id_ex.mem_wen;
            ex_mem.reg_wen    <= id_ex.reg_wen;
        end
    end

endmodule

`default_nettype wire

// File: rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dcache_stall,
    input  rv_pkg::ex_mem_t ex_mem,
    output logic            dcache_ren,
    output logic            dcache_wen,
    output logic [29:0]     dcache_addr,
    output logic [31:0]     dcache_wdata,
    input  logic [31:0]     dcache_rdata,
    output rv_pkg::wb_t     wb
);

    rv_pkg::mem_wb_t mem_wb;
    logic            hold;

    assign dcache_ren   = ex_mem.valid && ex_mem.mem_ren;
    assign dcache_wen   = ex_mem.valid && ex_mem.mem_wen;
    assign dcache_addr  = ex_mem.result[31:2];
    assign dcache_wdata = ex_mem.store_data;

    // a stall only matters while an access is pending
    assign hold = dcache_stall && (dcache_ren || dcache_wen);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid      <= ex_mem.valid && !hold;
            mem_wb.result     <= ex_mem.result;
            mem_wb.load_data  <= dcache_rdata;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.mem_to_reg <= ex_mem.mem_ren;
            mem_wb.reg_wen    <= ex_mem.reg_wen;
        end
    end

    assign wb.wen  = mem_wb.valid && mem_wb.reg_wen;
    assign wb.rd   = mem_wb.rd;
    assign wb.data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

endmodule

`default_nettype wire

// File: rv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        icache_stall,
    output logic        icache_ren,
    output logic        icache_wen,
    output logic [29:0] icache_addr,
    input  logic [31:0] icache_rdata,
    output logic [31:0] icache_wdata,
    input  logic        dcache_stall,
    output logic        dcache_ren,
    output logic        dcache_wen,
    output logic [29:0] dcache_addr,
    input  logic [31:0] dcache_rdata,
    output logic [31:0] dcache_wdata,
    output logic [31:0] pc
);

    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::wb_t       wb;
    rv_pkg::redirect_t redirect;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;
    logic              load_use;
    logic              mem_hold;

    // instruction side is read only
    assign icache_wen   = 1'b0;
    assign icache_wdata = 32'd0;
    assign pc           = {icache_addr, 2'b00};

    // pending data access freezes everything up to execute
    assign mem_hold = dcache_stall && (dcache_ren || dcache_wen);

    rv_fetch i_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (mem_hold || load_use),
        .icache_stall (icache_stall),
        .redirect     (redirect),
        .icache_ren   (icache_ren),
        .icache_addr  (icache_addr),
        .icache_rdata (icache_rdata),
        .if_id        (if_id)
    );

    rv_decode i_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (mem_hold),
        .flush    (redirect.taken),
        .if_id    (if_id),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .load_use (load_use),
        .id_ex    (id_ex)
    );

    rv_regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute i_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (mem_hold),
        .id_ex    (id_ex),
        .wb       (wb),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    rv_result i_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .dcache_stall (dcache_stall),
        .ex_mem       (ex_mem),
        .dcache_ren   (dcache_ren),
        .dcache_wen   (dcache_wen),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_rdata (dcache_rdata),
        .wb           (wb)
    );

endmodule

`default_nettype wire

// File: rv_pipeline_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        dcache_stall,
    input logic        dcache_ren,
    input logic        dcache_wen,
    input logic [29:0] dcache_addr,
    input logic [31:0] dcache_wdata
);

    // one access per cycle at most
    a_strobe_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(dcache_ren && dcache_wen)
    ) else $error("data cache read and write strobes are high together");

    // a stalled access must not change under the cache
    a_stall_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dcache_stall && (dcache_ren || dcache_wen)) |=>
            ($stable(dcache_ren) && $stable(dcache_wen) &&
             $stable(dcache_addr) && $stable(dcache_wdata))
    ) else $error("data cache request changed while the cache was stalled");

    a_reset_quiet: assert property (
        @(posedge clk)
        $rose(rst_n) |-> (!dcache_ren && !dcache_wen)
    ) else $error("data cache strobe active in the first cycle after reset");

endmodule

bind rv_pipeline rv_pipeline_assert i_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .dcache_stall (dcache_stall),
    .dcache_ren   (dcache_ren),
    .dcache_wen   (dcache_wen),
    .dcache_addr  (dcache_addr),
    .dcache_wdata (dcache_wdata)
);

`default_nettype wire

// File: tb_rv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module tb_rv_pipeline;

    localparam int num_tests = 10;
    localparam int num_progs = 5;
    localparam int prog_len  = 12;
    localparam int num_pre   = 4;
    localparam int mem_words = 64;
    localparam int max_wait  = 200;

    logic        clk;
    logic        rst_n;
    logic        icache_stall;
    logic        icache_ren;
    logic        icache_wen;
    logic [29:0] icache_addr;
    logic [31:0] icache_rdata;
    logic [31:0] icache_wdata;
    logic        dcache_stall;
    logic        dcache_ren;
    logic        dcache_wen;
    logic [29:0] dcache_addr;
    logic [31:0] dcache_rdata;
    logic [31:0] dcache_wdata;
    logic [31:0] pc;
    logic        stall_en;

    logic [31:0] imem [mem_words];
    logic [31:0] dmem [mem_words];

    // one row per test: program, stall mode, data preload, expected first store
    string       test_name    [num_tests];
    logic [31:0] program_word [num_tests][prog_len];
    logic        rand_stall   [num_tests];
    logic [31:0] preload      [num_tests][num_pre];
    logic [31:0] exp_addr     [num_tests];
    logic [31:0] exp_data     [num_tests];

    int error_count;
    int failed_tests;

    rv_pipeline i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .icache_stall (icache_stall),
        .icache_ren   (icache_ren),
        .icache_wen   (icache_wen),
        .icache_addr  (icache_addr),
        .icache_rdata (icache_rdata),
        .icache_wdata (icache_wdata),
        .dcache_stall (dcache_stall),
        .dcache_ren   (dcache_ren),
        .dcache_wen   (dcache_wen),
        .dcache_addr  (dcache_addr),
        .dcache_rdata (dcache_rdata),
        .dcache_wdata (dcache_wdata),
        .pc           (pc)
    );

    // both memories answer in the same cycle
    assign icache_rdata = imem[icache_addr[5:0]];
    assign dcache_rdata = dmem[dcache_addr[5:0]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cache stalls, about one cycle in four when enabled
    initial begin
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            icache_stall = stall_en && (($urandom % 4) == 0);
            dcache_stall = stall_en && (($urandom % 4) == 0);
        end
    end

    // RV32 instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    // word store only
    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] funct3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic set_row(input int t, input string name, input logic [31:0] addr,
                           input logic [31:0] data);
        test_name[t]  = name;
        exp_addr[t]   = addr;
        exp_data[t]   = data;
        rand_stall[t] = 1'b0;
        for (int k = 0; k < num_pre; k++) begin
            preload[t][k] = 32'h5a5a_0000 + 32'(k);
        end
        for (int k = 0; k < prog_len; k++) begin
            program_word[t][k] = `RV_NOP;
        end
    endtask

    task automatic build_table();
        // x7 = slt(x4 ^ x3, 0) + (x4 ^ x3) with x4 = -100, x3 = 197
        set_row(0, "alu_chain", 32'd2, 32'hffff_ff5a);
        program_word[0][0] = i_type(`RV_OP_IMM, 3'h0, 5'd1, 5'd0, 12'd100);
        program_word[0][1] = i_type(`RV_OP_IMM, 3'h0, 5'd2, 5'd1, 12'hffd);
        program_word[0][2] = r_type(7'h00, 3'h0, 5'd3, 5'd2, 5'd1);
        program_word[0][3] = r_type(7'h20, 3'h0, 5'd4, 5'd2, 5'd3);
        program_word[0][4] = r_type(7'h00, 3'h4, 5'd5, 5'd4, 5'd3);
        program_word[0][5] = r_type(7'h00, 3'h2, 5'd6, 5'd5, 5'd0);
        program_word[0][6] = r_type(7'h00, 3'h0, 5'd7, 5'd6, 5'd5);
        program_word[0][7] = s_type(5'd7, 5'd0, 12'd8);
        program_word[0][8] = j_type(5'd0, 21'd0);

        // loaded word plus 0x55, used right after the load
        set_row(1, "load_use", 32'd3, 32'h1234_56cd);
        preload[1][1]      = 32'h1234_5678;
        program_word[1][0] = i_type(`RV_OP_IMM, 3'h0, 5'd3, 5'd0, 12'h055);
        program_word[1][1] = i_type(`RV_OP_LOAD, 3'h2, 5'd1, 5'd0, 12'd4);
        program_word[1][2] = r_type(7'h00, 3'h0, 5'd2, 5'd1, 5'd3);
        program_word[1][3] = s_type(5'd2, 5'd0, 12'd12);
        program_word[1][4] = j_type(5'd0, 21'd0);

        // 1234 * -77 = 0xfffe8cd6, plus 0x12345000
        set_row(2, "mul_lui", 32'd4, 32'h1232_dcd6);
        program_word[2][0] = i_type(`RV_OP_IMM, 3'h0, 5'd1, 5'd0, 12'd1234);
        program_word[2][1] = i_type(`RV_OP_IMM, 3'h0, 5'd2, 5'd0, 12'hfb3);
        program_word[2][2] = r_type(7'h01, 3'h0, 5'd3, 5'd1, 5'd2);
        program_word[2][3] = u_type(5'd4, 20'h12345);
        program_word[2][4] = r_type(7'h00, 3'h0, 5'd5, 5'd3, 5'd4);
        program_word[2][5] = s_type(5'd5, 5'd0, 12'd16);
        program_word[2][6] = j_type(5'd0, 21'd0);

        // taken beq skips the marker store, bne falls through to add 0x40
        set_row(3, "branches", 32'd5, 32'h0000_0043);
        program_word[3][0] = i_type(`RV_OP_IMM, 3'h0, 5'd1, 5'd0, 12'd9);
        program_word[3][1] = i_type(`RV_OP_IMM, 3'h0, 5'd2, 5'd0, 12'd9);
        program_word[3][2] = b_type(3'h0, 5'd1, 5'd2, 13'd12);
        program_word[3][3] = i_type(`RV_OP_IMM, 3'h0, 5'd3, 5'd0, 12'hfff);
        program_word[3][4] = s_type(5'd3, 5'd0, 12'd20);
        program_word[3][5] = i_type(`RV_OP_IMM, 3'h0, 5'd4, 5'd0, 12'd3);
        program_word[3][6] = b_type(3'h1, 5'd1, 5'd2, 13'd8);
        program_word[3][7] = i_type(`RV_OP_IMM, 3'h0, 5'd4, 5'd4, 12'h040);
        program_word[3][8] = s_type(5'd4, 5'd0, 12'd20);
        program_word[3][9] = j_type(5'd0, 21'd0);

        // jal at pc 4 links 8 into x5
        set_row(4, "jal_link", 32'd6, 32'h0000_0008);
        program_word[4][0] = i_type(`RV_OP_IMM, 3'h0, 5'd1, 5'd0, 12'd1);
        program_word[4][1] = j_type(5'd5, 21'd12);
        program_word[4][2] = i_type(`RV_OP_IMM, 3'h0, 5'd5, 5'd0, 12'h077);
        program_word[4][3] = s_type(5'd5, 5'd0, 12'd24);
        program_word[4][4] = s_type(5'd5, 5'd0, 12'd24);
        program_word[4][5] = j_type(5'd0, 21'd0);

        // same programs again under random cache stalls
        for (int t = 0; t < num_progs; t++) begin
            test_name[t + num_progs]  = {test_name[t], "_stall"};
            exp_addr[t + num_progs]   = exp_addr[t];
            exp_data[t + num_progs]   = exp_data[t];
            rand_stall[t + num_progs] = 1'b1;
            for (int k = 0; k < prog_len; k++) begin
                program_word[t + num_progs][k] = program_word[t][k];
            end
            for (int k = 0; k < num_pre; k++) begin
                preload[t + num_progs][k] = preload[t][k];
            end
        end
    endtask

    task automatic load_memories(input int t);
        for (int i = 0; i < mem_words; i++) begin
            // harmless writes to x0, tagged with the word address
            imem[i] = i_type(`RV_OP_IMM, 3'h0, 5'd0, 5'd0, 12'(i));
            dmem[i] = 32'hd0d0_0000 | 32'(i);
        end
        for (int k = 0; k < prog_len; k++) begin
            imem[k] = program_word[t][k];
        end
        for (int k = 0; k < num_pre; k++) begin
            dmem[k] = preload[t][k];
        end
    endtask

    task automatic run_test(input int t);
        int   waited;
        int   errors_before;
        logic seen;
        waited        = 0;
        seen          = 1'b0;
        errors_before = error_count;
        stall_en      = rand_stall[t];
        @(posedge clk);
        #2;
        rst_n    = 1'b0;
        load_memories(t);
        repeat (5) @(posedge clk);
        #2;
        check({test_name[t], " reset pc"}, `RV_RESET_PC, pc);
        rst_n = 1'b1;
        while (!seen && waited < max_wait) begin
            @(negedge clk);
            if (dcache_wen) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!seen) begin
            $display("test %s: no store reached the data cache within %0d cycles",
                     test_name[t], max_wait);
            failed_tests++;
        end else begin
            check({test_name[t], " store address"}, exp_addr[t], {2'b00, dcache_addr});
            check({test_name[t], " store data"}, exp_data[t], dcache_wdata);
            check({test_name[t], " dcache read strobe"}, 32'd0, {31'd0, dcache_ren});
            // instruction side is read every cycle and never written
            check({test_name[t], " icache read strobe"}, 32'd1, {31'd0, icache_ren});
            check({test_name[t], " icache write strobe"}, 32'd0, {31'd0, icache_wen});
            check({test_name[t], " icache write data"}, 32'd0, icache_wdata);
            if (error_count == errors_before) begin
                $display("test %s passed", test_name[t]);
            end else begin
                $display("test %s failed", test_name[t]);
                failed_tests++;
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        stall_en     = 1'b0;
        error_count  = 0;
        failed_tests = 0;
        void'($urandom(32'h2c9f));
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d failed, %0d mismatches",
                 num_tests, failed_tests, error_count);
        if (failed_tests == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_pipeline.sv
rv_pipeline_assert.sv
tb_rv_pipeline.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and fail on a bad exit or a reported failure
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_rv_pipeline \
    -o tb_rv_pipeline > build.log 2>&1 &&
    ./obj_dir/tb_rv_pipeline > sim.log 2>&1 &&
    ! grep -q "TESTS FAILED" sim.log &&
    { cat sim.log; echo "run.sh: simulation passed"; exit 0; } ||
    { cat build.log sim.log 2>/dev/null; echo "run.sh: simulation failed"; exit 1; }
